//--- hw/local_mem_pkg.sv
package local_mem_pkg;

  localparam int DATA_WIDTH     = 64;
  localparam int WORDS_PER_LINE = 8;
  localparam int BYTES_PER_WORD = DATA_WIDTH / 8;

  typedef logic [DATA_WIDTH-1:0]                     word_t;
  typedef logic [WORDS_PER_LINE*DATA_WIDTH-1:0]      line_t;
  typedef logic [BYTES_PER_WORD-1:0]                 byteen_t;
  typedef logic [WORDS_PER_LINE*BYTES_PER_WORD-1:0]  line_byteen_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]         word_sel_t;

  // Host register map
  typedef enum logic [2:0] {
    CTRL      = 3'd0,
    ADDRESS   = 3'd1,
    WRITEDATA = 3'd2,
    READDATA  = 3'd3,
    STATUS    = 3'd4
  } csr_index_t;

  // Control word fields
  localparam int CTRL_WR_A   = 0;
  localparam int CTRL_RD_A   = 1;
  localparam int CTRL_WR_B   = 2;
  localparam int CTRL_RD_B   = 3;
  localparam int CTRL_BE_LSB = 4;
  localparam int CTRL_SEL_LSB = 16;
  localparam int CTRL_BC_LSB = 20;

  // Status word bits, the rest read as zero
  localparam int STAT_DATA_VALID   = 0;
  localparam int STAT_A_WR_TIMEOUT = 1;
  localparam int STAT_A_RD_TIMEOUT = 2;
  localparam int STAT_A_FIFO_FULL  = 3;
  localparam int STAT_B_WR_TIMEOUT = 4;
  localparam int STAT_B_RD_TIMEOUT = 5;
  localparam int STAT_B_FIFO_FULL  = 6;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ_CMD,
    READ_WAIT
  } mem_if_state_t;

endpackage

//--- hw/csr_regs.sv
`timescale 1ns/100ps

module csr_regs
  import local_mem_pkg::*;
(
  input  logic       Clk_400,
  input  logic       rst_n,
  input  logic       host_write,
  input  logic       host_read,
  input  csr_index_t host_addr,
  input  word_t      host_writedata,
  input  word_t      mem_readdata,
  input  word_t      mem_status,
  output word_t      host_readdata,
  output logic       host_readvalid,
  output word_t      ctrl_word,
  output logic [3:0] cmd_pulse,
  output word_t      mem_address,
  output word_t      mem_writedata
);

  word_t ctrl_reg;

  // Command bits never stay set in the stored control value
  assign ctrl_word = {ctrl_reg[DATA_WIDTH-1:4], 4'b0000};

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      ctrl_reg  <= '0;
      cmd_pulse <= 4'b0000;
    end else begin
      cmd_pulse <= 4'b0000;
      if (host_write && host_addr == CTRL) begin
        ctrl_reg  <= host_writedata;
        cmd_pulse <= host_writedata[3:0];
      end
    end
  end

  always_ff @(posedge Clk_400) begin
    if (host_write && host_addr == ADDRESS) begin
      mem_address <= host_writedata;
    end
    if (host_write && host_addr == WRITEDATA) begin
      mem_writedata <= host_writedata;
    end
  end

  // Read response one cycle after the strobe
  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      host_readvalid <= 1'b0;
    end else begin
      host_readvalid <= host_read;
    end
  end

  always_ff @(posedge Clk_400) begin
    if (host_read) begin
      case (host_addr)
        CTRL:      host_readdata <= ctrl_word;
        ADDRESS:   host_readdata <= mem_address;
        WRITEDATA: host_readdata <= mem_writedata;
        READDATA:  host_readdata <= mem_readdata;
        STATUS:    host_readdata <= mem_status;
        default:   host_readdata <= '0;
      endcase
    end
  end

  a_no_rw_overlap: assert property (@(posedge Clk_400) disable iff (!rst_n)
    !(host_write && host_read));

endmodule

//--- hw/cmd_fifo.sv
`timescale 1ns/100ps

module cmd_fifo #(
  parameter int FIFO_DEPTH  = 4,
  parameter int ENTRY_WIDTH = 32
) (
  input  logic                   Clk_400,
  input  logic                   rst_n,
  input  logic                   push,
  input  logic [ENTRY_WIDTH-1:0] push_entry,
  input  logic                   pop,
  output logic [ENTRY_WIDTH-1:0] pop_entry,
  output logic                   empty,
  output logic                   full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [ENTRY_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   do_push;

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(FIFO_DEPTH));
  assign do_push   = push && !full;
  assign pop_entry = mem[rd_ptr];

  always_ff @(posedge Clk_400) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_pop_empty: assert property (@(posedge Clk_400) disable iff (!rst_n)
    pop |-> !empty);

endmodule

//--- hw/mem_if.sv
`timescale 1ns/100ps

module mem_if
  import local_mem_pkg::*;
#(
  parameter int ADDR_WIDTH       = 26,
  parameter int BURSTCOUNT_WIDTH = 7,
  parameter int FIFO_DEPTH       = 4,
  parameter int TIMEOUT_CYCLES   = 64
) (
  input  logic                        Clk_400,
  input  logic                        rst_n,
  input  logic                        write,
  input  logic                        read,
  input  logic [ADDR_WIDTH-1:0]       address,
  input  word_t                       writedata,
  input  byteen_t                     byteenable,
  input  logic [BURSTCOUNT_WIDTH-1:0] burstcount,
  input  word_sel_t                   word_sel,
  input  logic                        ddr_waitrequest,
  input  line_t                       ddr_readdata,
  input  logic                        ddr_readdatavalid,
  output word_t                       readdata,
  output logic                        data_ready,
  output logic                        cmd_fifo_full,
  output logic                        wr_timeout,
  output logic                        rd_timeout,
  output logic                        ddr_read,
  output logic                        ddr_write,
  output logic [ADDR_WIDTH-1:0]       ddr_address,
  output line_t                       ddr_writedata,
  output line_byteen_t                ddr_byteenable,
  output logic [BURSTCOUNT_WIDTH-1:0] ddr_burstcount
);

  // Entry is {op, word_sel, burstcount, byteenable, writedata, address}
  localparam int ENTRY_WIDTH = 1 + $bits(word_sel_t) + BURSTCOUNT_WIDTH
                             + $bits(byteen_t) + DATA_WIDTH + ADDR_WIDTH;
  localparam int TIMER_W     = $clog2(TIMEOUT_CYCLES);

  mem_if_state_t               state;
  logic [TIMER_W-1:0]          timer;
  logic                        timer_done;
  logic                        fifo_empty;
  logic                        pop;
  logic [ENTRY_WIDTH-1:0]      pop_entry;
  logic                        pop_op;
  word_sel_t                   pop_sel;
  logic [BURSTCOUNT_WIDTH-1:0] pop_bc;
  byteen_t                     pop_be;
  word_t                       pop_wdata;
  logic [ADDR_WIDTH-1:0]       pop_addr;
  word_sel_t                   cmd_sel;
  word_t                       cmd_wdata;
  byteen_t                     cmd_be;
  logic                        wr_expire;
  logic                        rd_expire;

  // A read wins if both strobes arrive together
  cmd_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .ENTRY_WIDTH (ENTRY_WIDTH)
  ) u_cmd_fifo (
    .Clk_400    (Clk_400),
    .rst_n      (rst_n),
    .push       (write || read),
    .push_entry ({read, word_sel, burstcount, byteenable, writedata, address}),
    .pop        (pop),
    .pop_entry  (pop_entry),
    .empty      (fifo_empty),
    .full       (cmd_fifo_full)
  );

  assign {pop_op, pop_sel, pop_bc, pop_be, pop_wdata, pop_addr} = pop_entry;

  assign pop        = (state == IDLE) && !fifo_empty;
  assign timer_done = (timer == TIMER_W'(TIMEOUT_CYCLES - 1));
  assign wr_expire  = (state == WRITE) && ddr_waitrequest && timer_done;
  assign rd_expire  = timer_done
                    && (((state == READ_CMD) && ddr_waitrequest)
                    || ((state == READ_WAIT) && !ddr_readdatavalid));

  assign ddr_write      = (state == WRITE);
  assign ddr_read       = (state == READ_CMD);
  assign ddr_writedata  = {WORDS_PER_LINE{cmd_wdata}};
  assign ddr_byteenable = {WORDS_PER_LINE{cmd_be}};

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      state <= IDLE;
      timer <= '0;
    end else begin
      timer <= timer + 1'b1;
      case (state)
        IDLE: begin
          timer <= '0;
          if (pop) begin
            state <= pop_op ? READ_CMD : WRITE;
          end
        end
        WRITE: begin
          if (!ddr_waitrequest || timer_done) begin
            state <= IDLE;
          end
        end
        READ_CMD: begin
          if (!ddr_waitrequest) begin
            state <= READ_WAIT;
            timer <= '0;
          end else if (timer_done) begin
            state <= IDLE;
          end
        end
        READ_WAIT: begin
          if (ddr_readdatavalid || timer_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Command held on the DDR port while it is outstanding
  always_ff @(posedge Clk_400) begin
    if (pop) begin
      ddr_address    <= pop_addr;
      ddr_burstcount <= pop_bc;
      cmd_wdata      <= pop_wdata;
      cmd_be         <= pop_be;
      cmd_sel        <= pop_sel;
    end
    if (state == READ_WAIT && ddr_readdatavalid) begin
      readdata <= ddr_readdata[cmd_sel*DATA_WIDTH +: DATA_WIDTH];
    end
  end

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      data_ready <= 1'b0;
      wr_timeout <= 1'b0;
      rd_timeout <= 1'b0;
    end else begin
      data_ready <= (state == READ_WAIT) && ddr_readdatavalid;
      if (wr_expire) begin
        wr_timeout <= 1'b1;
      end else if (write) begin
        wr_timeout <= 1'b0;
      end
      if (rd_expire) begin
        rd_timeout <= 1'b1;
      end else if (read) begin
        rd_timeout <= 1'b0;
      end
    end
  end

  a_one_request: assert property (@(posedge Clk_400) disable iff (!rst_n)
    !(ddr_read && ddr_write));

endmodule

//--- hw/local_mem.sv
`timescale 1ns/100ps

module local_mem
  import local_mem_pkg::*;
#(
  parameter int ADDR_WIDTH       = 26,
  parameter int BURSTCOUNT_WIDTH = 7,
  parameter int FIFO_DEPTH       = 4,
  parameter int TIMEOUT_CYCLES   = 64
) (
  input  logic                        Clk_400,
  input  logic                        rst_n,
  input  word_t                       ctrl_word,
  input  logic [3:0]                  cmd_pulse,
  input  word_t                       mem_address,
  input  word_t                       mem_writedata,
  output word_t                       mem_readdata,
  output word_t                       mem_status,
  input  logic                        ddr4a_waitrequest,
  input  line_t                       ddr4a_readdata,
  input  logic                        ddr4a_readdatavalid,
  output logic                        ddr4a_read,
  output logic                        ddr4a_write,
  output logic [ADDR_WIDTH-1:0]       ddr4a_address,
  output line_t                       ddr4a_writedata,
  output line_byteen_t                ddr4a_byteenable,
  output logic [BURSTCOUNT_WIDTH-1:0] ddr4a_burstcount,
  input  logic                        ddr4b_waitrequest,
  input  line_t                       ddr4b_readdata,
  input  logic                        ddr4b_readdatavalid,
  output logic                        ddr4b_read,
  output logic                        ddr4b_write,
  output logic [ADDR_WIDTH-1:0]       ddr4b_address,
  output line_t                       ddr4b_writedata,
  output line_byteen_t                ddr4b_byteenable,
  output logic [BURSTCOUNT_WIDTH-1:0] ddr4b_burstcount
);

  // Fields shared by both channels
  byteen_t                     byteen;
  word_sel_t                   word_sel;
  logic [BURSTCOUNT_WIDTH-1:0] burstcount;
  logic [ADDR_WIDTH-1:0]       address;

  logic  rd_a, rd_b;
  word_t readdata_a, readdata_b;
  logic  ready_a, ready_b;
  logic  full_a, full_b;
  logic  wr_to_a, wr_to_b;
  logic  rd_to_a, rd_to_b;
  logic  pend_a, pend_b;
  logic  rd_done;
  logic  data_valid;
  logic  sel_b;

  assign byteen     = ctrl_word[CTRL_BE_LSB +: $bits(byteen_t)];
  assign word_sel   = ctrl_word[CTRL_SEL_LSB +: $bits(word_sel_t)];
  assign burstcount = ctrl_word[CTRL_BC_LSB +: BURSTCOUNT_WIDTH];
  assign address    = mem_address[ADDR_WIDTH-1:0];
  assign rd_a       = cmd_pulse[CTRL_RD_A];
  assign rd_b       = cmd_pulse[CTRL_RD_B];

  always_ff @(posedge Clk_400) begin
    if (!rst_n) begin
      pend_a     <= 1'b0;
      pend_b     <= 1'b0;
      rd_done    <= 1'b0;
      data_valid <= 1'b0;
      sel_b      <= 1'b0;
    end else begin
      pend_a  <= rd_a || (pend_a && !ready_a);
      pend_b  <= rd_b || (pend_b && !ready_b);
      rd_done <= (pend_a && ready_a) || (pend_b && ready_b);
      // A new read clears the flag before the previous result can set it
      if (rd_a || rd_b) begin
        data_valid <= 1'b0;
        sel_b      <= rd_b;
      end else if (rd_done) begin
        data_valid <= 1'b1;
      end
    end
  end

  assign mem_readdata = sel_b ? readdata_b : readdata_a;

  always_comb begin
    mem_status                    = '0;
    mem_status[STAT_DATA_VALID]   = data_valid;
    mem_status[STAT_A_WR_TIMEOUT] = wr_to_a;
    mem_status[STAT_A_RD_TIMEOUT] = rd_to_a;
    mem_status[STAT_A_FIFO_FULL]  = full_a;
    mem_status[STAT_B_WR_TIMEOUT] = wr_to_b;
    mem_status[STAT_B_RD_TIMEOUT] = rd_to_b;
    mem_status[STAT_B_FIFO_FULL]  = full_b;
  end

  mem_if #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
  ) u_ddr4a_if (
    .Clk_400           (Clk_400),
    .rst_n             (rst_n),
    .write             (cmd_pulse[CTRL_WR_A]),
    .read              (rd_a),
    .address           (address),
    .writedata         (mem_writedata),
    .byteenable        (byteen),
    .burstcount        (burstcount),
    .word_sel          (word_sel),
    .ddr_waitrequest   (ddr4a_waitrequest),
    .ddr_readdata      (ddr4a_readdata),
    .ddr_readdatavalid (ddr4a_readdatavalid),
    .readdata          (readdata_a),
    .data_ready        (ready_a),
    .cmd_fifo_full     (full_a),
    .wr_timeout        (wr_to_a),
    .rd_timeout        (rd_to_a),
    .ddr_read          (ddr4a_read),
    .ddr_write         (ddr4a_write),
    .ddr_address       (ddr4a_address),
    .ddr_writedata     (ddr4a_writedata),
    .ddr_byteenable    (ddr4a_byteenable),
    .ddr_burstcount    (ddr4a_burstcount)
  );

  mem_if #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
  ) u_ddr4b_if (
    .Clk_400           (Clk_400),
    .rst_n             (rst_n),
    .write             (cmd_pulse[CTRL_WR_B]),
    .read              (rd_b),
    .address           (address),
    .writedata         (mem_writedata),
    .byteenable        (byteen),
    .burstcount        (burstcount),
    .word_sel          (word_sel),
    .ddr_waitrequest   (ddr4b_waitrequest),
    .ddr_readdata      (ddr4b_readdata),
    .ddr_readdatavalid (ddr4b_readdatavalid),
    .readdata          (readdata_b),
    .data_ready        (ready_b),
    .cmd_fifo_full     (full_b),
    .wr_timeout        (wr_to_b),
    .rd_timeout        (rd_to_b),
    .ddr_read          (ddr4b_read),
    .ddr_write         (ddr4b_write),
    .ddr_address       (ddr4b_address),
    .ddr_writedata     (ddr4b_writedata),
    .ddr_byteenable    (ddr4b_byteenable),
    .ddr_burstcount    (ddr4b_burstcount)
  );

  // The read-data mux can follow only one channel at a time
  a_single_read: assert property (@(posedge Clk_400) disable iff (!rst_n)
    !(rd_a && rd_b));

endmodule

//--- hw/local_mem_top.sv
`timescale 1ns/100ps

module local_mem_top
  import local_mem_pkg::*;
#(
  parameter int ADDR_WIDTH       = 26,
  parameter int BURSTCOUNT_WIDTH = 7,
  parameter int FIFO_DEPTH       = 4,
  parameter int TIMEOUT_CYCLES   = 64
) (
  input  logic                        Clk_400,
  input  logic                        rst_n,
  input  logic                        host_write,
  input  logic                        host_read,
  input  csr_index_t                  host_addr,
  input  word_t                       host_writedata,
  output word_t                       host_readdata,
  output logic                        host_readvalid,
  input  logic                        ddr4a_waitrequest,
  input  line_t                       ddr4a_readdata,
  input  logic                        ddr4a_readdatavalid,
  output logic                        ddr4a_read,
  output logic                        ddr4a_write,
  output logic [ADDR_WIDTH-1:0]       ddr4a_address,
  output line_t                       ddr4a_writedata,
  output line_byteen_t                ddr4a_byteenable,
  output logic [BURSTCOUNT_WIDTH-1:0] ddr4a_burstcount,
  input  logic                        ddr4b_waitrequest,
  input  line_t                       ddr4b_readdata,
  input  logic                        ddr4b_readdatavalid,
  output logic                        ddr4b_read,
  output logic                        ddr4b_write,
  output logic [ADDR_WIDTH-1:0]       ddr4b_address,
  output line_t                       ddr4b_writedata,
  output line_byteen_t                ddr4b_byteenable,
  output logic [BURSTCOUNT_WIDTH-1:0] ddr4b_burstcount
);

  word_t      ctrl_word;
  logic [3:0] cmd_pulse;
  word_t      mem_address;
  word_t      mem_writedata;
  word_t      mem_readdata;
  word_t      mem_status;

  csr_regs u_csr_regs (
    .Clk_400        (Clk_400),
    .rst_n          (rst_n),
    .host_write     (host_write),
    .host_read      (host_read),
    .host_addr      (host_addr),
    .host_writedata (host_writedata),
    .mem_readdata   (mem_readdata),
    .mem_status     (mem_status),
    .host_readdata  (host_readdata),
    .host_readvalid (host_readvalid),
    .ctrl_word      (ctrl_word),
    .cmd_pulse      (cmd_pulse),
    .mem_address    (mem_address),
    .mem_writedata  (mem_writedata)
  );

  local_mem #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
  ) u_local_mem (
    .Clk_400             (Clk_400),
    .rst_n               (rst_n),
    .ctrl_word           (ctrl_word),
    .cmd_pulse           (cmd_pulse),
    .mem_address         (mem_address),
    .mem_writedata       (mem_writedata),
    .mem_readdata        (mem_readdata),
    .mem_status          (mem_status),
    .ddr4a_waitrequest   (ddr4a_waitrequest),
    .ddr4a_readdata      (ddr4a_readdata),
    .ddr4a_readdatavalid (ddr4a_readdatavalid),
    .ddr4a_read          (ddr4a_read),
    .ddr4a_write         (ddr4a_write),
    .ddr4a_address       (ddr4a_address),
    .ddr4a_writedata     (ddr4a_writedata),
    .ddr4a_byteenable    (ddr4a_byteenable),
    .ddr4a_burstcount    (ddr4a_burstcount),
    .ddr4b_waitrequest   (ddr4b_waitrequest),
    .ddr4b_readdata      (ddr4b_readdata),
    .ddr4b_readdatavalid (ddr4b_readdatavalid),
    .ddr4b_read          (ddr4b_read),
    .ddr4b_write         (ddr4b_write),
    .ddr4b_address       (ddr4b_address),
    .ddr4b_writedata     (ddr4b_writedata),
    .ddr4b_byteenable    (ddr4b_byteenable),
    .ddr4b_burstcount    (ddr4b_burstcount)
  );

endmodule

//--- sim/ddr_model.sv
`timescale 1ns/100ps

module ddr_model
  import local_mem_pkg::*;
#(
  parameter int ADDR_WIDTH = 26
) (
  input  logic                  Clk_400,
  input  logic                  rst_n,
  input  logic                  stall,
  input  logic                  read,
  input  logic                  write,
  input  logic [ADDR_WIDTH-1:0] address,
  input  line_t                 writedata,
  input  line_byteen_t          byteenable,
  output logic                  waitrequest,
  output line_t                 readdata,
  output logic                  readdatavalid
);

  // Sixteen lines, indexed by the low address bits
  line_t      mem [16];
  line_t      rd_line;
  logic       rd_busy;
  logic [2:0] rd_delay;
  logic [3:0] idx;

  assign idx = address[3:0];

  always @(posedge Clk_400) begin
    if (!rst_n) begin
      // Each word starts as its line and word number
      for (int i = 0; i < 16; i++) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          mem[i][w*DATA_WIDTH +: DATA_WIDTH] <= {32'(i), 32'(w)};
        end
      end
    end else if (write && !waitrequest) begin
      for (int b = 0; b < WORDS_PER_LINE * BYTES_PER_WORD; b++) begin
        if (byteenable[b]) begin
          mem[idx][b*8 +: 8] <= writedata[b*8 +: 8];
        end
      end
    end
  end

  // One read in flight, returned after a random delay
  always @(posedge Clk_400) begin
    if (!rst_n) begin
      waitrequest   <= 1'b0;
      readdatavalid <= 1'b0;
      rd_busy       <= 1'b0;
      rd_delay      <= 3'd0;
    end else begin
      waitrequest   <= stall || ($urandom % 4 == 0);
      readdatavalid <= 1'b0;
      if (read && !waitrequest) begin
        rd_line  <= mem[idx];
        rd_delay <= 3'($urandom % 8);
        rd_busy  <= 1'b1;
      end else if (rd_busy) begin
        if (rd_delay == 3'd0) begin
          readdata      <= rd_line;
          readdatavalid <= 1'b1;
          rd_busy       <= 1'b0;
        end else begin
          rd_delay <= rd_delay - 3'd1;
        end
      end
    end
  end

endmodule

//--- sim/tb_local_mem.sv
`timescale 1ns/100ps

module tb_local_mem
  import local_mem_pkg::*;
();

  localparam int ADDR_WIDTH       = 26;
  localparam int BURSTCOUNT_WIDTH = 7;
  localparam int FIFO_DEPTH       = 4;
  localparam int TIMEOUT_CYCLES   = 64;
  localparam int POLL_LIMIT       = 400;
  localparam int BURST_LEN        = 1;

  logic                        Clk_400;
  logic                        rst_n;
  logic                        host_write;
  logic                        host_read;
  csr_index_t                  host_addr;
  word_t                       host_writedata;
  word_t                       host_readdata;
  logic                        host_readvalid;
  logic                        stall_a;
  logic                        stall_b;
  logic                        ddr4a_waitrequest;
  line_t                       ddr4a_readdata;
  logic                        ddr4a_readdatavalid;
  logic                        ddr4a_read;
  logic                        ddr4a_write;
  logic [ADDR_WIDTH-1:0]       ddr4a_address;
  line_t                       ddr4a_writedata;
  line_byteen_t                ddr4a_byteenable;
  logic [BURSTCOUNT_WIDTH-1:0] ddr4a_burstcount;
  logic                        ddr4b_waitrequest;
  line_t                       ddr4b_readdata;
  logic                        ddr4b_readdatavalid;
  logic                        ddr4b_read;
  logic                        ddr4b_write;
  logic [ADDR_WIDTH-1:0]       ddr4b_address;
  line_t                       ddr4b_writedata;
  line_byteen_t                ddr4b_byteenable;
  logic [BURSTCOUNT_WIDTH-1:0] ddr4b_burstcount;

  // Expected line contents per channel
  line_t shadow_a [16];
  line_t shadow_b [16];

  string chk_name;
  word_t chk_exp;
  word_t chk_got;
  event  chk_ev;
  int    cmp_count  = 0;
  int    cmp_errors = 0;
  int    checks     = 0;
  int    errors     = 0;

  local_mem_top #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .BURSTCOUNT_WIDTH (BURSTCOUNT_WIDTH),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .TIMEOUT_CYCLES   (TIMEOUT_CYCLES)
  ) u_local_mem_top (.*);

  ddr_model #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ddr4a_model (
    .Clk_400       (Clk_400),
    .rst_n         (rst_n),
    .stall         (stall_a),
    .read          (ddr4a_read),
    .write         (ddr4a_write),
    .address       (ddr4a_address),
    .writedata     (ddr4a_writedata),
    .byteenable    (ddr4a_byteenable),
    .waitrequest   (ddr4a_waitrequest),
    .readdata      (ddr4a_readdata),
    .readdatavalid (ddr4a_readdatavalid)
  );

  ddr_model #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ddr4b_model (
    .Clk_400       (Clk_400),
    .rst_n         (rst_n),
    .stall         (stall_b),
    .read          (ddr4b_read),
    .write         (ddr4b_write),
    .address       (ddr4b_address),
    .writedata     (ddr4b_writedata),
    .byteenable    (ddr4b_byteenable),
    .waitrequest   (ddr4b_waitrequest),
    .readdata      (ddr4b_readdata),
    .readdatavalid (ddr4b_readdatavalid)
  );

  initial begin
    Clk_400 = 1'b0;
    forever begin
      #50 Clk_400 = ~Clk_400;
    end
  end

  // Byte-enable merge of one word into all eight words of a line
  function automatic line_t ref_line_update(line_t old_line, word_t data, byteen_t be);
    line_t new_line;
    new_line = old_line;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (be[b]) begin
          new_line[w*DATA_WIDTH + b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    return new_line;
  endfunction

  function automatic word_t make_ctrl(int cmd_bit, byteen_t be, word_sel_t sel);
    word_t w;
    w = '0;
    w[cmd_bit] = 1'b1;
    w[CTRL_BE_LSB +: BYTES_PER_WORD] = be;
    w[CTRL_SEL_LSB +: $bits(word_sel_t)] = sel;
    w[CTRL_BC_LSB +: BURSTCOUNT_WIDTH] = BURSTCOUNT_WIDTH'(BURST_LEN);
    return w;
  endfunction

  // All host tasks start and end 1 ns after a rising edge
  task automatic host_wr(input csr_index_t idx, input word_t data);
    host_write     = 1'b1;
    host_addr      = idx;
    host_writedata = data;
    @(posedge Clk_400);
    #1;
    host_write = 1'b0;
  endtask

  task automatic host_rd(input csr_index_t idx, output word_t data);
    int n;
    host_read = 1'b1;
    host_addr = idx;
    @(posedge Clk_400);
    #1;
    host_read = 1'b0;
    n = 0;
    while (!host_readvalid && n < 8) begin
      @(posedge Clk_400);
      #1;
      n++;
    end
    if (!host_readvalid) begin
      $display("Host read of register %0d got no response", idx);
      errors++;
    end
    data = host_readdata;
  endtask

  task automatic wait_status(input int bit_pos, input string what, output word_t status);
    int n;
    n = 0;
    host_rd(STATUS, status);
    while (!status[bit_pos] && n < POLL_LIMIT) begin
      host_rd(STATUS, status);
      n++;
    end
    if (!status[bit_pos]) begin
      $display("Status bit %s never came up", what);
      errors++;
    end
  endtask

  task automatic issue_write(input bit ch_b, input logic [3:0] idx, input word_t data,
                             input byteen_t be);
    host_wr(ADDRESS, word_t'(idx));
    host_wr(WRITEDATA, data);
    host_wr(CTRL, make_ctrl(ch_b ? CTRL_WR_B : CTRL_WR_A, be, 3'd0));
  endtask

  task automatic mem_write(input bit ch_b, input logic [3:0] idx, input word_t data,
                           input byteen_t be);
    issue_write(ch_b, idx, data, be);
    if (ch_b) begin
      shadow_b[idx] = ref_line_update(shadow_b[idx], data, be);
    end else begin
      shadow_a[idx] = ref_line_update(shadow_a[idx], data, be);
    end
  endtask

  task automatic mem_read(input bit ch_b, input logic [3:0] idx, input word_sel_t sel,
                          input string name);
    word_t status;
    word_t got;
    line_t exp_line;
    host_wr(ADDRESS, word_t'(idx));
    host_wr(CTRL, make_ctrl(ch_b ? CTRL_RD_B : CTRL_RD_A, 8'hff, sel));
    // DATA_VALID of the last read drops one cycle after the pulse
    @(posedge Clk_400);
    #1;
    wait_status(STAT_DATA_VALID, "DATA_VALID", status);
    host_rd(READDATA, got);
    exp_line = ch_b ? shadow_b[idx] : shadow_a[idx];
    chk_name = name;
    chk_exp  = exp_line[sel*DATA_WIDTH +: DATA_WIDTH];
    chk_got  = got;
    -> chk_ev;
  endtask

  always @(chk_ev) begin
    cmp_count++;
    if (chk_got !== chk_exp) begin
      $display("Fail %s: expected %h, actual %h", chk_name, chk_exp, chk_got);
      cmp_errors++;
    end
  end

  // Each accepted request forwards the burst count of its command
  always @(posedge Clk_400) begin
    if (rst_n && (ddr4a_read || ddr4a_write) && !ddr4a_waitrequest) begin
      checks++;
      if (ddr4a_burstcount !== BURSTCOUNT_WIDTH'(BURST_LEN)) begin
        $display("Fail burstcount_a: expected %h, actual %h",
                 BURSTCOUNT_WIDTH'(BURST_LEN), ddr4a_burstcount);
        errors++;
      end
    end
    if (rst_n && (ddr4b_read || ddr4b_write) && !ddr4b_waitrequest) begin
      checks++;
      if (ddr4b_burstcount !== BURSTCOUNT_WIDTH'(BURST_LEN)) begin
        $display("Fail burstcount_b: expected %h, actual %h",
                 BURSTCOUNT_WIDTH'(BURST_LEN), ddr4b_burstcount);
        errors++;
      end
    end
  end

  initial begin
    word_t      status;
    word_t      data;
    logic [3:0] idx;
    bit         ch_b;
    void'($urandom(88));
    rst_n          = 1'b0;
    host_write     = 1'b0;
    host_read      = 1'b0;
    host_addr      = CTRL;
    host_writedata = '0;
    stall_a        = 1'b0;
    stall_b        = 1'b0;
    // Model lines power up holding line and word number
    for (int i = 0; i < 16; i++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        shadow_a[i][w*DATA_WIDTH +: DATA_WIDTH] = {32'(i), 32'(w)};
        shadow_b[i][w*DATA_WIDTH +: DATA_WIDTH] = {32'(i), 32'(w)};
      end
    end
    repeat (10) @(posedge Clk_400);
    #1;
    rst_n = 1'b1;
    @(posedge Clk_400);
    #1;

    host_rd(STATUS, status);
    checks++;
    if (status !== '0) begin
      $display("Fail reset_status: expected %h, actual %h", word_t'(0), status);
      errors++;
    end

    mem_write(1'b0, 4'd2, 64'h0123_4567_89ab_cdef, 8'hff);
    for (int s = 0; s < WORDS_PER_LINE; s++) begin
      mem_read(1'b0, 4'd2, word_sel_t'(s), "full_write_a");
    end

    mem_write(1'b0, 4'd2, 64'hfedc_ba98_7654_3210, 8'h0f);
    mem_read(1'b0, 4'd2, 3'd5, "partial_be_low");
    mem_write(1'b0, 4'd2, 64'h1111_2222_3333_4444, 8'ha5);
    mem_read(1'b0, 4'd2, 3'd1, "partial_be_mixed");
    mem_write(1'b0, 4'd9, 64'hdead_beef_cafe_f00d, 8'h80);
    mem_read(1'b0, 4'd9, 3'd7, "partial_be_top");

    mem_write(1'b1, 4'd2, 64'h5555_aaaa_5555_aaaa, 8'hff);
    mem_read(1'b0, 4'd2, 3'd3, "a_after_b_write");
    mem_read(1'b1, 4'd2, 3'd3, "b_readback");
    mem_read(1'b0, 4'd2, 3'd0, "a_after_b_read");

    for (int i = 0; i < 40; i++) begin
      ch_b = 1'($urandom % 2);
      idx  = 4'($urandom % 16);
      if ($urandom % 2 == 0) begin
        data = {$urandom, $urandom};
        mem_write(ch_b, idx, data, byteen_t'($urandom % 256));
      end else begin
        mem_read(ch_b, idx, word_sel_t'($urandom % 8), "random_read");
      end
    end

    // Let queued writes drain before the stall
    repeat (20) @(posedge Clk_400);
    #1;
    stall_b = 1'b1;
    repeat (2) @(posedge Clk_400);
    #1;
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      issue_write(1'b1, 4'd15, word_t'(i), 8'hff);
    end
    wait_status(STAT_B_FIFO_FULL, "B_FIFO_FULL", status);
    wait_status(STAT_B_WR_TIMEOUT, "B_WR_TIMEOUT", status);
    stall_b = 1'b0;
    repeat (40) @(posedge Clk_400);
    #1;
    mem_write(1'b1, 4'd3, 64'h0f0f_1234_5678_f0f0, 8'hff);
    mem_read(1'b1, 4'd3, 3'd6, "b_after_stall");
    host_rd(STATUS, status);
    checks++;
    if (status[STAT_B_WR_TIMEOUT] !== 1'b0) begin
      $display("Fail b_timeout_clear: expected %h, actual %h", 1'b0,
               status[STAT_B_WR_TIMEOUT]);
      errors++;
    end

    repeat (3) @(posedge Clk_400);
    $display("Checks: %0d, errors: %0d", checks + cmp_count, errors + cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (100000) @(posedge Clk_400);
    $display("Simulation ran past its cycle limit");
    $display("Checks: %0d, errors: %0d", checks + cmp_count, errors + cmp_errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- verilog.f
hw/local_mem_pkg.sv
hw/csr_regs.sv
hw/cmd_fifo.sv
hw/mem_if.sv
hw/local_mem.sv
hw/local_mem_top.sv
sim/ddr_model.sv
sim/tb_local_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the local memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_local_mem -o tb_local_mem \
  && ./obj_dir/tb_local_mem | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
